/* rv_core.f */
src/rv_core_pkg.sv
src/rv_registers.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memory.sv
src/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

/* src/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
	parameter logic [31:0] RESET_VECTOR = rv_core_pkg::RESET_VECTOR_DEFAULT
)(
	input logic i_reset,
	input logic i_clock,

	// Instruction bus
	output logic o_ibus_request,
	input logic i_ibus_ready,
	output logic [31:0] o_ibus_address,
	input logic [31:0] i_ibus_rdata,

	// Data bus
	output logic o_dbus_rw,
	output logic o_dbus_request,
	input logic i_dbus_ready,
	output logic [31:0] o_dbus_address,
	input logic [31:0] i_dbus_rdata,
	output logic [31:0] o_dbus_wdata,

	output logic o_fault
);

	logic f_valid;
	logic [31:0] f_pc;
	logic [31:0] f_insn;

	logic d_valid;
	rv_core_pkg::insn_class_e d_class;
	rv_core_pkg::alu_op_e d_alu_op;
	logic [4:0] d_rd;
	logic [31:0] d_rs1_val;
	logic [31:0] d_rs2_val;
	logic [31:0] d_imm;
	logic [31:0] d_pc;
	logic d_use_imm;
	logic d_stall;

	logic e_valid;
	rv_core_pkg::insn_class_e e_class;
	logic [4:0] e_rd;
	logic [31:0] e_result;
	logic [31:0] e_store_data;

	logic wb_en;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;

	logic jump;
	logic [31:0] jump_pc;
	logic mem_busy;

	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic ex_writes;
	logic [4:0] ex_rd;
	logic mem_writes;
	logic [4:0] mem_rd;

	//==========================================================
	// Registers

	rv_registers registers (
		.i_clock(i_clock),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_wr_en(wb_en),
		.i_wr_addr(wb_rd),
		.i_wr_data(wb_data)
	);

	//==========================================================
	// Fetch

	rv_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(d_stall | mem_busy),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.o_ibus_request(o_ibus_request),
		.o_ibus_address(o_ibus_address),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_rdata(i_ibus_rdata),
		.o_valid(f_valid),
		.o_pc(f_pc),
		.o_insn(f_insn)
	);

	//==========================================================
	// Decode

	rv_decode decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall_mem(mem_busy),
		.i_flush(jump),
		.i_valid(f_valid),
		.i_pc(f_pc),
		.i_insn(f_insn),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_ex_rd(ex_rd),
		.i_ex_writes(ex_writes),
		.i_mem_rd(mem_rd),
		.i_mem_writes(mem_writes),
		.o_stall(d_stall),
		.o_fault(o_fault),
		.o_valid(d_valid),
		.o_class(d_class),
		.o_alu_op(d_alu_op),
		.o_rd(d_rd),
		.o_rs1_val(d_rs1_val),
		.o_rs2_val(d_rs2_val),
		.o_imm(d_imm),
		.o_pc(d_pc),
		.o_use_imm(d_use_imm)
	);

	//==========================================================
	// Execute

	rv_execute execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall_mem(mem_busy),
		.i_valid(d_valid),
		.i_class(d_class),
		.i_alu_op(d_alu_op),
		.i_rd(d_rd),
		.i_rs1_val(d_rs1_val),
		.i_rs2_val(d_rs2_val),
		.i_imm(d_imm),
		.i_pc(d_pc),
		.i_use_imm(d_use_imm),
		.o_jump(jump),
		.o_jump_pc(jump_pc),
		.o_writes(ex_writes),
		.o_ex_rd(ex_rd),
		.o_valid(e_valid),
		.o_class(e_class),
		.o_rd(e_rd),
		.o_result(e_result),
		.o_store_data(e_store_data)
	);

	//==========================================================
	// Memory and writeback

	rv_memory memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(e_valid),
		.i_class(e_class),
		.i_rd(e_rd),
		.i_result(e_result),
		.i_store_data(e_store_data),
		.o_dbus_request(o_dbus_request),
		.o_dbus_rw(o_dbus_rw),
		.o_dbus_address(o_dbus_address),
		.o_dbus_wdata(o_dbus_wdata),
		.i_dbus_ready(i_dbus_ready),
		.i_dbus_rdata(i_dbus_rdata),
		.o_busy(mem_busy),
		.o_wr_en(wb_en),
		.o_wr_addr(wb_rd),
		.o_wr_data(wb_data),
		.o_writes(mem_writes),
		.o_rd(mem_rd)
	);

endmodule

`default_nettype wire

/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

	//==========================================================
	// ALU operation

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	//==========================================================
	// Instruction class

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JAL,
		CLS_NONE
	} insn_class_e;

	// RV32I major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	localparam logic [31:0] RESET_VECTOR_DEFAULT = 32'h0000_0000;

endpackage

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall_mem,
	input logic i_flush,

	// From fetch
	input logic i_valid,
	input logic [31:0] i_pc,
	input logic [31:0] i_insn,

	// Register file
	output logic [4:0] o_rs1_addr,
	output logic [4:0] o_rs2_addr,
	input logic [31:0] i_rs1_data,
	input logic [31:0] i_rs2_data,

	// Pending writes for the interlock
	input logic [4:0] i_ex_rd,
	input logic i_ex_writes,
	input logic [4:0] i_mem_rd,
	input logic i_mem_writes,

	output logic o_stall,
	output logic o_fault,

	// To execute
	output logic o_valid,
	output rv_core_pkg::insn_class_e o_class,
	output rv_core_pkg::alu_op_e o_alu_op,
	output logic [4:0] o_rd,
	output logic [31:0] o_rs1_val,
	output logic [31:0] o_rs2_val,
	output logic [31:0] o_imm,
	output logic [31:0] o_pc,
	output logic o_use_imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	rv_core_pkg::insn_class_e cls;
	rv_core_pkg::alu_op_e op;
	logic [31:0] imm;
	logic [4:0] dst;
	logic use_imm;
	logic use_rs1;
	logic use_rs2;
	logic legal;
	logic rs1_hit;
	logic rs2_hit;

	assign opcode = i_insn[6:0];
	assign rd = i_insn[11:7];
	assign funct3 = i_insn[14:12];
	assign rs1 = i_insn[19:15];
	assign rs2 = i_insn[24:20];

	assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
	assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
	assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
	assign imm_u = {i_insn[31:12], 12'd0};
	assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

	// funct3 to ALU op, alt selects SUB/SRA from bit 30
	function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_sel = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			3'b001: alu_sel = rv_core_pkg::ALU_SLL;
			3'b010: alu_sel = rv_core_pkg::ALU_SLT;
			3'b011: alu_sel = rv_core_pkg::ALU_SLTU;
			3'b100: alu_sel = rv_core_pkg::ALU_XOR;
			3'b101: alu_sel = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
			3'b110: alu_sel = rv_core_pkg::ALU_OR;
			default: alu_sel = rv_core_pkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		cls = rv_core_pkg::CLS_NONE;
		op = rv_core_pkg::ALU_ADD;
		imm = imm_i;
		dst = 5'd0;
		use_imm = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		legal = 1'b1;
		case (opcode)
			rv_core_pkg::OPC_OP: begin
				cls = rv_core_pkg::CLS_ALU;
				op = alu_sel(funct3, i_insn[30]);
				dst = rd;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_core_pkg::OPC_OPIMM: begin
				cls = rv_core_pkg::CLS_ALU;
				// Only shifts take the alternate bit here
				op = alu_sel(funct3, i_insn[30] && funct3 == 3'b101);
				dst = rd;
				use_imm = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_core_pkg::OPC_LUI: begin
				cls = rv_core_pkg::CLS_ALU;
				op = rv_core_pkg::ALU_PASS_B;
				imm = imm_u;
				dst = rd;
				use_imm = 1'b1;
			end
			rv_core_pkg::OPC_LOAD: begin
				cls = rv_core_pkg::CLS_LOAD;
				dst = rd;
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				legal = (funct3 == 3'b010);
			end
			rv_core_pkg::OPC_STORE: begin
				cls = rv_core_pkg::CLS_STORE;
				imm = imm_s;
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				legal = (funct3 == 3'b010);
			end
			rv_core_pkg::OPC_BRANCH: begin
				// BEQ compares via SUB, BNE via XOR
				cls = rv_core_pkg::CLS_BRANCH;
				op = funct3[0] ? rv_core_pkg::ALU_XOR : rv_core_pkg::ALU_SUB;
				imm = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				legal = (funct3[2:1] == 2'b00);
			end
			rv_core_pkg::OPC_JAL: begin
				cls = rv_core_pkg::CLS_JAL;
				imm = imm_j;
				dst = rd;
			end
			default: legal = 1'b0;
		endcase
	end

	//==========================================================
	// Interlock

	assign rs1_hit = use_rs1 && rs1 != 5'd0 &&
		((i_ex_writes && i_ex_rd == rs1) || (i_mem_writes && i_mem_rd == rs1));
	assign rs2_hit = use_rs2 && rs2 != 5'd0 &&
		((i_ex_writes && i_ex_rd == rs2) || (i_mem_writes && i_mem_rd == rs2));

	assign o_stall = i_valid && (rs1_hit || rs2_hit);

	assign o_rs1_addr = rs1;
	assign o_rs2_addr = rs2;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_fault <= 1'b0;
		end else if (!i_stall_mem) begin
			o_valid <= i_valid && legal && !o_stall && !i_flush;
			if (i_valid && !legal && !i_flush)
				o_fault <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_stall_mem) begin
			o_class <= cls;
			o_alu_op <= op;
			o_rd <= dst;
			o_rs1_val <= i_rs1_data;
			o_rs2_val <= i_rs2_data;
			o_imm <= imm;
			o_pc <= i_pc;
			o_use_imm <= use_imm;
		end
	end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall_mem,

	// From decode
	input logic i_valid,
	input rv_core_pkg::insn_class_e i_class,
	input rv_core_pkg::alu_op_e i_alu_op,
	input logic [4:0] i_rd,
	input logic [31:0] i_rs1_val,
	input logic [31:0] i_rs2_val,
	input logic [31:0] i_imm,
	input logic [31:0] i_pc,
	input logic i_use_imm,

	// Control
	output logic o_jump,
	output logic [31:0] o_jump_pc,

	// Destination of the instruction now executing
	output logic o_writes,
	output logic [4:0] o_ex_rd,

	// To memory
	output logic o_valid,
	output rv_core_pkg::insn_class_e o_class,
	output logic [4:0] o_rd,
	output logic [31:0] o_result,
	output logic [31:0] o_store_data
);

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] alu;
	logic taken;

	assign a = i_rs1_val;
	assign b = i_use_imm ? i_imm : i_rs2_val;

	always_comb begin
		case (i_alu_op)
			rv_core_pkg::ALU_ADD: alu = a + b;
			rv_core_pkg::ALU_SUB: alu = a - b;
			rv_core_pkg::ALU_SLL: alu = a << b[4:0];
			rv_core_pkg::ALU_SLT: alu = {31'd0, $signed(a) < $signed(b)};
			rv_core_pkg::ALU_SLTU: alu = {31'd0, a < b};
			rv_core_pkg::ALU_XOR: alu = a ^ b;
			rv_core_pkg::ALU_SRL: alu = a >> b[4:0];
			rv_core_pkg::ALU_SRA: alu = $unsigned($signed(a) >>> b[4:0]);
			rv_core_pkg::ALU_OR: alu = a | b;
			rv_core_pkg::ALU_AND: alu = a & b;
			default: alu = b;
		endcase
	end

	// Zero ALU result means equal for both SUB and XOR
	assign taken = (i_alu_op == rv_core_pkg::ALU_SUB) ? (alu == 32'd0) : (alu != 32'd0);

	assign o_jump = i_valid && !i_stall_mem &&
		((i_class == rv_core_pkg::CLS_BRANCH && taken) || i_class == rv_core_pkg::CLS_JAL);
	assign o_jump_pc = i_pc + i_imm;

	// Decode leaves rd zero for stores and branches
	assign o_writes = i_valid && i_rd != 5'd0;
	assign o_ex_rd = i_rd;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (!i_stall_mem)
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (!i_stall_mem) begin
			o_class <= i_class;
			o_rd <= i_rd;
			o_result <= (i_class == rv_core_pkg::CLS_JAL) ? i_pc + 32'd4 : alu;
			o_store_data <= i_rs2_val;
		end
	end

endmodule

`default_nettype wire

/* src/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
	parameter logic [31:0] RESET_VECTOR = rv_core_pkg::RESET_VECTOR_DEFAULT
)(
	input logic i_clock,
	input logic i_reset,

	// Control
	input logic i_stall,
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Instruction bus
	output logic o_ibus_request,
	output logic [31:0] o_ibus_address,
	input logic i_ibus_ready,
	input logic [31:0] i_ibus_rdata,

	// To decode
	output logic o_valid,
	output logic [31:0] o_pc,
	output logic [31:0] o_insn
);

	logic req_q;
	logic discard_q;
	logic [31:0] addr_q;
	logic [31:0] target_q;
	logic take;

	assign take = req_q && i_ibus_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			req_q <= 1'b1;
			addr_q <= RESET_VECTOR;
			discard_q <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			if (take) begin
				if (i_jump)
					addr_q <= i_jump_pc;
				else if (discard_q)
					addr_q <= target_q;
				else if (!i_stall)
					addr_q <= addr_q + 32'd4;
				// A word dropped on stall is fetched again once the stall clears
				req_q <= !i_stall || i_jump || discard_q;
				discard_q <= 1'b0;
			end else if (req_q) begin
				// Outstanding fetch runs to completion, its word is dropped
				if (i_jump) begin
					discard_q <= 1'b1;
					target_q <= i_jump_pc;
				end
			end else begin
				if (i_jump)
					addr_q <= i_jump_pc;
				req_q <= !i_stall || i_jump;
			end

			if (i_jump)
				o_valid <= 1'b0;
			else if (!i_stall)
				o_valid <= take && !discard_q;
		end
	end

	// Fetched word, held while stalled
	always_ff @(posedge i_clock) begin
		if (!i_stall) begin
			o_pc <= addr_q;
			o_insn <= i_ibus_rdata;
		end
	end

	assign o_ibus_request = req_q;
	assign o_ibus_address = addr_q;

endmodule

`default_nettype wire

/* src/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory (
	input logic i_clock,
	input logic i_reset,

	// From execute
	input logic i_valid,
	input rv_core_pkg::insn_class_e i_class,
	input logic [4:0] i_rd,
	input logic [31:0] i_result,
	input logic [31:0] i_store_data,

	// Data bus
	output logic o_dbus_request,
	output logic o_dbus_rw,
	output logic [31:0] o_dbus_address,
	output logic [31:0] o_dbus_wdata,
	input logic i_dbus_ready,
	input logic [31:0] i_dbus_rdata,

	output logic o_busy,

	// Register writeback
	output logic o_wr_en,
	output logic [4:0] o_wr_addr,
	output logic [31:0] o_wr_data,

	// Write still pending for the interlock
	output logic o_writes,
	output logic [4:0] o_rd
);

	logic req_q;
	logic is_load;
	logic is_mem;
	logic done;

	assign is_load = (i_class == rv_core_pkg::CLS_LOAD);
	assign is_mem = i_valid && (is_load || i_class == rv_core_pkg::CLS_STORE);
	assign done = req_q && i_dbus_ready;

	// Busy from the first cycle of the access until ready
	assign o_busy = is_mem && !done;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			req_q <= 1'b0;
		else
			req_q <= is_mem && !done;
	end

	// Address and data come straight from the frozen execute register
	assign o_dbus_request = req_q;
	assign o_dbus_rw = (i_class == rv_core_pkg::CLS_STORE);
	assign o_dbus_address = i_result;
	assign o_dbus_wdata = i_store_data;

	assign o_wr_en = i_valid && i_rd != 5'd0 && (!is_load || done);
	assign o_wr_addr = i_rd;
	assign o_wr_data = is_load ? i_dbus_rdata : i_result;

	assign o_writes = i_valid && i_rd != 5'd0 && !o_wr_en;
	assign o_rd = i_rd;

endmodule

`default_nettype wire

/* src/rv_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_registers (
	input logic i_clock,

	input logic [4:0] i_rs1_addr,
	input logic [4:0] i_rs2_addr,
	output logic [31:0] o_rs1_data,
	output logic [31:0] o_rs2_data,

	input logic i_wr_en,
	input logic [4:0] i_wr_addr,
	input logic [31:0] i_wr_data
);

	// x1 to x31, x0 is not stored
	logic [31:0] regs [31:1];

	always_ff @(posedge i_clock) begin
		if (i_wr_en && i_wr_addr != 5'd0)
			regs[i_wr_addr] <= i_wr_data;
	end

	// Write port bypasses into both reads
	assign o_rs1_data = (i_rs1_addr == 5'd0) ? 32'd0 :
		(i_wr_en && i_wr_addr == i_rs1_addr) ? i_wr_data : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == 5'd0) ? 32'd0 :
		(i_wr_en && i_wr_addr == i_rs2_addr) ? i_wr_data : regs[i_rs2_addr];

endmodule

`default_nettype wire

/* verification/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
	input logic i_clock,
	input logic i_reset,
	input logic i_dbus_request,
	input logic i_dbus_rw,
	input logic i_dbus_ready,
	input logic [31:0] i_dbus_address,
	input logic [31:0] i_dbus_wdata,
	input logic i_fault,
	output int o_errors,
	output int o_stores
);

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic fault_seen;

	task automatic add_expected(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	initial begin
		o_errors = 0;
		o_stores = 0;
		fault_seen = 1'b0;
	end

	//==========================================================
	// Stores in program order

	always @(posedge i_clock) begin
		if (!i_reset && i_dbus_request && i_dbus_rw && i_dbus_ready) begin
			if (o_stores >= exp_addr.size()) begin
				$display("Store to %h after the end of the program", i_dbus_address);
				o_errors++;
			end else begin
				if (i_dbus_address !== exp_addr[o_stores]) begin
					$display("ERR dbus_address expected %h got %h",
						exp_addr[o_stores], i_dbus_address);
					o_errors++;
				end
				if (i_dbus_wdata !== exp_data[o_stores]) begin
					$display("ERR dbus_wdata at %h expected %h got %h",
						exp_addr[o_stores], exp_data[o_stores], i_dbus_wdata);
					o_errors++;
				end
			end
			o_stores++;
		end
	end

	// Fault is sticky and only rises near the end of the program
	always @(posedge i_clock) begin
		if (!i_reset) begin
			if (fault_seen && i_fault !== 1'b1) begin
				$display("Fault output dropped after it was raised");
				o_errors++;
			end
			if (!fault_seen && i_fault === 1'b1) begin
				fault_seen = 1'b1;
				if (o_stores + 1 < exp_addr.size()) begin
					$display("Fault raised early, after only %0d stores", o_stores);
					o_errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/rv_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
	input logic i_clock,
	input logic i_reset,
	input logic o_ibus_request,
	input logic i_ibus_ready,
	input logic [31:0] o_ibus_address,
	input logic o_dbus_request,
	input logic o_dbus_rw,
	input logic i_dbus_ready,
	input logic [31:0] o_dbus_address,
	input logic [31:0] o_dbus_wdata,
	input logic o_fault
);

	// Failed assertions, read by the testbench
	int fail_count = 0;

	// Request held with a stable address until ready
	ibus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ibus_request && !i_ibus_ready |=> o_ibus_request && $stable(o_ibus_address))
	else begin
		fail_count++;
		$error("ibus request dropped or address changed before ready");
	end

	dbus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_dbus_request && !i_dbus_ready |=>
		o_dbus_request && $stable(o_dbus_address) && $stable(o_dbus_rw) &&
		$stable(o_dbus_wdata))
	else begin
		fail_count++;
		$error("dbus request dropped or changed before ready");
	end

	// First reset edge loads the registers
	dbus_idle_in_reset: assert property (@(posedge i_clock)
		i_reset && $past(i_reset) |-> !o_dbus_request)
	else begin
		fail_count++;
		$error("dbus request during reset");
	end

	fault_low_after_reset: assert property (@(posedge i_clock)
		$fell(i_reset) |-> !o_fault)
	else begin
		fail_count++;
		$error("fault high after reset");
	end

endmodule

bind rv_core rv_core_props props (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.o_ibus_request(o_ibus_request),
	.i_ibus_ready(i_ibus_ready),
	.o_ibus_address(o_ibus_address),
	.o_dbus_request(o_dbus_request),
	.o_dbus_rw(o_dbus_rw),
	.i_dbus_ready(i_dbus_ready),
	.o_dbus_address(o_dbus_address),
	.o_dbus_wdata(o_dbus_wdata),
	.o_fault(o_fault)
);

`default_nettype wire

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam logic [31:0] BOOT = 32'h0000_0000;
	localparam logic [31:0] DATA_ADDR = 32'h0000_0380;
	localparam int TIMEOUT = 20000;

	// Table operations
	localparam int T_ADD = 0, T_SUB = 1, T_SLL = 2, T_SLT = 3, T_SLTU = 4, T_XOR = 5;
	localparam int T_SRL = 6, T_SRA = 7, T_OR = 8, T_AND = 9;
	localparam int T_ADDI = 10, T_SLTI = 11, T_SLTIU = 12, T_XORI = 13, T_ORI = 14;
	localparam int T_ANDI = 15, T_SLLI = 16, T_SRLI = 17, T_SRAI = 18;
	localparam int T_LUI = 19, T_LW = 20, T_BEQ = 21, T_BNE = 22, T_JAL = 23;

	logic i_clock;
	logic i_reset;
	logic o_ibus_request;
	logic i_ibus_ready;
	logic [31:0] o_ibus_address;
	logic [31:0] i_ibus_rdata;
	logic o_dbus_rw;
	logic o_dbus_request;
	logic i_dbus_ready;
	logic [31:0] o_dbus_address;
	logic [31:0] i_dbus_rdata;
	logic [31:0] o_dbus_wdata;
	logic o_fault;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] rng = 32'h400c_2178;
	int iwait;
	int dwait;
	int n_words;
	int n_expected;
	int check_errors;
	int store_count;
	int run_errors;

	int tab_op [$];
	logic [31:0] tab_a [$];
	logic [31:0] tab_b [$];
	bit tab_rnd [$];

	rv_core #(
		.RESET_VECTOR(BOOT)
	) UUT (
		.i_reset(i_reset),
		.i_clock(i_clock),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_dbus_rw(o_dbus_rw),
		.o_dbus_request(o_dbus_request),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_fault(o_fault)
	);

	rv_core_checker store_check (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_dbus_request(o_dbus_request),
		.i_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready),
		.i_dbus_address(o_dbus_address),
		.i_dbus_wdata(o_dbus_wdata),
		.i_fault(o_fault),
		.o_errors(check_errors),
		.o_stores(store_count)
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Address mixed through an odd multiplier
	function automatic logic [31:0] mix(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
	endfunction

	// Illegal opcode in the low bits, rest from the mixed address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		logic [31:0] m;
		m = mix(addr);
		return {m[31:7], 7'h7f};
	endfunction

	function automatic logic [31:0] sra(input logic [31:0] a, input logic [4:0] sh);
		logic [31:0] r;
		r = a >> sh;
		if (a[31])
			r = r | ~(32'hffff_ffff >> sh);
		return r;
	endfunction

	// Negative is less when signs differ, plain compare otherwise
	function automatic logic [31:0] less_signed(input logic [31:0] a, input logic [31:0] b);
		if (a[31] != b[31])
			return {31'd0, a[31]};
		else
			return {31'd0, a < b};
	endfunction

	//==========================================================
	// Reference results from the RV32I rules

	function automatic logic [31:0] ref_value(input int op, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] imm;
		logic [4:0] sh;
		imm = {{20{b[11]}}, b[11:0]};
		sh = b[4:0];
		case (op)
			T_ADD: return a + b;
			T_SUB: return a - b;
			T_SLL, T_SLLI: return a << sh;
			T_SLT: return less_signed(a, b);
			T_SLTU: return {31'd0, a < b};
			T_XOR: return a ^ b;
			T_SRL, T_SRLI: return a >> sh;
			T_SRA, T_SRAI: return sra(a, sh);
			T_OR: return a | b;
			T_AND: return a & b;
			T_ADDI: return a + imm;
			T_SLTI: return less_signed(a, imm);
			T_SLTIU: return {31'd0, a < imm};
			T_XORI: return a ^ imm;
			T_ORI: return a | imm;
			T_ANDI: return a & imm;
			T_LUI: return {b[31:12], 12'd0};
			default: return 32'd0;
		endcase
	endfunction

	// Bit 30 and funct3 of each ALU operation
	function automatic logic [3:0] funct_of(input int op);
		case (op)
			T_ADD, T_ADDI: return 4'b0000;
			T_SUB: return 4'b1000;
			T_SLL, T_SLLI: return 4'b0001;
			T_SLT, T_SLTI: return 4'b0010;
			T_SLTU, T_SLTIU: return 4'b0011;
			T_XOR, T_XORI: return 4'b0100;
			T_SRL, T_SRLI: return 4'b0101;
			T_SRA, T_SRAI: return 4'b1101;
			T_OR, T_ORI: return 4'b0110;
			default: return 4'b0111;
		endcase
	endfunction

	//==========================================================
	// Instruction encoders

	function automatic logic [31:0] enc_r(input logic [3:0] f, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [4:0] rd);
		return {1'b0, f[3], 5'd0, rs2, rs1, f[2:0], rd, rv_core_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
			rv_core_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[n_words] = word;
		n_words++;
	endtask

	// LUI plus ADDI, upper part rounded for the signed low part
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		emit({hi[31:12], rd, rv_core_pkg::OPC_LUI});
		emit(enc_i(v[11:0], rd, 3'b000, rd, rv_core_pkg::OPC_OPIMM));
	endtask

	task automatic add_entry(input int op, input logic [31:0] a, input logic [31:0] b,
		input bit rnd);
		tab_op.push_back(op);
		tab_a.push_back(a);
		tab_b.push_back(b);
		tab_rnd.push_back(rnd);
	endtask

	task automatic fill_table();
		add_entry(T_ADD, 32'h7fff_ffff, 32'h0000_0001, 0);
		add_entry(T_SUB, 0, 0, 1);
		add_entry(T_SLL, 0, 0, 1);
		add_entry(T_SLT, 32'hffff_fff0, 32'h0000_0005, 0);
		add_entry(T_SLTU, 32'hffff_fff0, 32'h0000_0005, 0);
		add_entry(T_XOR, 0, 0, 1);
		add_entry(T_SRL, 32'h8000_0000, 32'd31, 0);
		add_entry(T_SRA, 32'h8000_0010, 32'd4, 0);
		add_entry(T_SRA, 0, 0, 1);
		add_entry(T_OR, 0, 0, 1);
		add_entry(T_AND, 0, 0, 1);
		add_entry(T_ADDI, 32'd5, 32'h0000_0fff, 0);
		add_entry(T_SLTI, 0, 0, 1);
		add_entry(T_SLTIU, 32'd1, 32'h0000_0fff, 0);
		add_entry(T_XORI, 0, 0, 1);
		add_entry(T_ORI, 0, 0, 1);
		add_entry(T_ANDI, 0, 0, 1);
		add_entry(T_SLLI, 0, 0, 1);
		add_entry(T_SRLI, 0, 0, 1);
		add_entry(T_SRAI, 32'hf000_0000, 32'd8, 0);
		add_entry(T_LUI, 0, 0, 1);
		add_entry(T_LW, 0, 0, 0);
		add_entry(T_BEQ, 32'h1234_5678, 32'h1234_5678, 0);
		add_entry(T_BEQ, 32'd5, 32'd6, 0);
		add_entry(T_BNE, 32'd7, 32'd8, 0);
		add_entry(T_BNE, 32'd9, 32'd9, 0);
		add_entry(T_JAL, 0, 0, 0);
	endtask

	//==========================================================
	// Program built from the table

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] st;
		logic [31:0] exp;
		logic [3:0] f;
		int op;
		n_words = 0;
		for (int i = 0; i < tab_op.size(); i++) begin
			op = tab_op[i];
			a = tab_a[i];
			b = tab_b[i];
			if (tab_rnd[i]) begin
				rng = xorshift(rng);
				a = rng;
				rng = xorshift(rng);
				b = rng;
			end
			st = 32'h100 + 4 * i;
			f = funct_of(op);
			exp = ref_value(op, a, b);
			if (op <= T_AND) begin
				load_const(5'd1, a);
				load_const(5'd2, b);
				emit(enc_r(f, 5'd2, 5'd1, 5'd3));
			end else if (op >= T_SLLI && op <= T_SRAI) begin
				load_const(5'd1, a);
				emit(enc_i({1'b0, f[3], 5'd0, b[4:0]}, 5'd1, f[2:0], 5'd3,
					rv_core_pkg::OPC_OPIMM));
			end else if (op <= T_ANDI) begin
				load_const(5'd1, a);
				emit(enc_i(b[11:0], 5'd1, f[2:0], 5'd3, rv_core_pkg::OPC_OPIMM));
			end else if (op == T_LUI) begin
				emit({b[31:12], 5'd3, rv_core_pkg::OPC_LUI});
			end else if (op == T_LW) begin
				load_const(5'd1, DATA_ADDR);
				emit(enc_i(12'd0, 5'd1, 3'b010, 5'd3, rv_core_pkg::OPC_LOAD));
				exp = dmem[DATA_ADDR[9:2]];
			end else if (op == T_JAL) begin
				// Link is the address after the JAL, the marker ADDI is skipped
				exp = BOOT + 4 * n_words + 4;
				emit(enc_j(21'd8, 5'd3));
				emit(enc_i(12'd2, 5'd0, 3'b000, 5'd3, rv_core_pkg::OPC_OPIMM));
			end else begin
				load_const(5'd1, a);
				load_const(5'd2, b);
				emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, rv_core_pkg::OPC_OPIMM));
				emit(enc_b(13'd8, 5'd2, 5'd1, (op == T_BNE) ? 3'b001 : 3'b000));
				emit(enc_i(12'd2, 5'd0, 3'b000, 5'd3, rv_core_pkg::OPC_OPIMM));
				if ((op == T_BEQ) ? (a == b) : (a != b))
					exp = 32'd1;
				else
					exp = 32'd2;
			end
			emit(enc_s(st[11:0], 5'd3, 5'd0));
			store_check.add_expected(st, exp);
		end
		emit(32'hffff_ffff);
		n_expected = tab_op.size();
	endtask

	//==========================================================
	// Bus models, 0 to 3 wait states

	always @(negedge i_clock) begin
		// Instruction bus, a new wait is drawn after each completed fetch
		if (i_ibus_ready) begin
			rng = xorshift(rng);
			iwait = rng[1:0];
		end
		i_ibus_ready = 1'b0;
		if (o_ibus_request) begin
			if (iwait == 0) begin
				i_ibus_ready = 1'b1;
				if (o_ibus_address < 32'h400)
					i_ibus_rdata = imem[o_ibus_address[9:2]];
				else
					i_ibus_rdata = fill_word(o_ibus_address);
			end else begin
				iwait--;
			end
		end

		// Data bus
		if (i_dbus_ready) begin
			rng = xorshift(rng);
			dwait = rng[1:0];
		end
		i_dbus_ready = 1'b0;
		if (o_dbus_request) begin
			if (dwait == 0) begin
				i_dbus_ready = 1'b1;
				i_dbus_rdata = dmem[o_dbus_address[9:2]];
				if (o_dbus_rw)
					dmem[o_dbus_address[9:2]] = o_dbus_wdata;
			end else begin
				dwait--;
			end
		end
	end

	//==========================================================
	// Main sequence

	initial begin
		int cycles;
		i_reset = 1'b1;
		i_ibus_ready = 1'b0;
		i_ibus_rdata = 32'd0;
		i_dbus_ready = 1'b0;
		i_dbus_rdata = 32'd0;
		run_errors = 0;
		iwait = 0;
		dwait = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = fill_word(BOOT + 4 * i);
			dmem[i] = mix(4 * i);
		end
		rng = xorshift(rng);
		dmem[DATA_ADDR[9:2]] = rng;
		fill_table();
		build_program();

		repeat (10) @(negedge i_clock);
		i_reset = 1'b0;

		cycles = 0;
		while (o_fault !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (o_fault !== 1'b1) begin
			$display("Timed out waiting for the fault output");
			run_errors++;
		end

		cycles = 0;
		while (store_count < n_expected && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (store_count < n_expected) begin
			$display("Timed out waiting for the stores");
			run_errors++;
		end

		// Let any stray store after the fault show up
		cycles = 0;
		while (cycles < 50) begin
			@(negedge i_clock);
			cycles++;
		end

		$display("Done: %0d check errors, %0d assertion errors, %0d run errors, %0d/%0d stores",
			check_errors, UUT.props.fail_count, run_errors, store_count, n_expected);
		if (check_errors == 0 && UUT.props.fail_count == 0 && run_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
